//--- hdl/dac_ad5601_ctrl.sv
// top level of the AD5601 controller
// register map, transfer sequencer and serializer

module dac_ad5601_ctrl (
    input  logic               clk_ifc,
    input  logic               set_default_on_reset,

    // register bus
    input  dac_pkg::reg_addr_t address,
    input  logic               write,
    input  dac_pkg::bus_word_t writedata,
    input  logic               read,
    output logic               waitrequest,
    output dac_pkg::bus_word_t readdata,
    output logic               readdatavalid,
    output dac_pkg::bus_resp_t response,
    output logic               writeresponsevalid,

    // gain path
    input  logic               en_avmm_ctrl,
    input  dac_pkg::dac_gain_t dac_gain,
    input  logic               dac_gain_valid,

    output logic               dac_reg_updated,
    output logic               initdone,

    // AD5601 serial pins
    output logic               sync_n,
    output logic               sclk,
    output logic               sdin
);

    import dac_pkg::*;

    dac_word_t dac_word;
    logic      dac_write_stb;
    logic      shift_start;
    dac_word_t shift_word;
    logic      shift_busy;
    logic      shift_done;

    dac_reg_map dac_reg_map_inst (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .address              (address),
        .write                (write),
        .writedata            (writedata),
        .read                 (read),
        .waitrequest          (waitrequest),
        .readdata             (readdata),
        .readdatavalid        (readdatavalid),
        .response             (response),
        .writeresponsevalid   (writeresponsevalid),
        .en_avmm_ctrl         (en_avmm_ctrl),
        .dac_gain             (dac_gain),
        .dac_gain_valid       (dac_gain_valid),
        .dac_word             (dac_word),
        .dac_write_stb        (dac_write_stb)
    );

    dac_xfer_seq dac_xfer_seq_inst (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .dac_word             (dac_word),
        .dac_write_stb        (dac_write_stb),
        .shift_start          (shift_start),
        .shift_word           (shift_word),
        .shift_busy           (shift_busy),
        .shift_done           (shift_done),
        .dac_reg_updated      (dac_reg_updated),
        .initdone             (initdone)
    );

    dac_spi_shifter dac_spi_shifter_inst (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .shift_start          (shift_start),
        .shift_word           (shift_word),
        .shift_busy           (shift_busy),
        .shift_done           (shift_done),
        .sync_n               (sync_n),
        .sclk                 (sclk),
        .sdin                 (sdin)
    );

endmodule

//--- hdl/dac_pkg.sv
// shared types, register addresses and response codes
// for the AD5601 controller

package dac_pkg;

    typedef logic [3:0]  reg_addr_t;  // word address
    typedef logic [31:0] bus_word_t;
    typedef logic [1:0]  bus_resp_t;
    typedef logic [15:0] dac_word_t;  // one serial frame
    typedef logic [7:0]  dac_gain_t;

    typedef enum logic [1:0] {
        XFER_BOOT,
        XFER_IDLE,
        XFER_BUSY
    } xfer_state_t;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_END
    } spi_state_t;

    localparam bus_resp_t RESP_OKAY        = 2'd0;
    localparam bus_resp_t RESP_SLAVE_ERROR = 2'd2;

    localparam reg_addr_t REG_VERSION_ID   = 4'd0;
    localparam reg_addr_t REG_NUM_REGS     = 4'd1;
    localparam reg_addr_t REG_DEVICE_STATE = 4'd2;
    localparam reg_addr_t REG_DAC          = 4'd3;
    localparam reg_addr_t REG_EN_AVMM_CTRL = 4'd4; // read-only mirror

endpackage

//--- hdl/dac_reg_map.sv
// register bank and bus decode for the AD5601 controller
// also merges the gain strobe into the DAC register

`include "dac_cfg.svh"

module dac_reg_map (
    input  logic                clk_ifc,
    input  logic                set_default_on_reset,

    input  dac_pkg::reg_addr_t  address,
    input  logic                write,
    input  dac_pkg::bus_word_t  writedata,
    input  logic                read,
    output logic                waitrequest,
    output dac_pkg::bus_word_t  readdata,
    output logic                readdatavalid,
    output dac_pkg::bus_resp_t  response,
    output logic                writeresponsevalid,

    input  logic                en_avmm_ctrl,
    input  dac_pkg::dac_gain_t  dac_gain,
    input  logic                dac_gain_valid,

    output dac_pkg::dac_word_t  dac_word,
    output logic                dac_write_stb
);

    import dac_pkg::*;

    localparam bus_word_t VERSION_ID_WORD   = {`DAC_MODULE_VERSION, `DAC_MODULE_ID};
    localparam bus_word_t NUM_REGS_WORD     = bus_word_t'(`DAC_NUM_REGS);
    localparam bus_word_t DEVICE_STATE_WORD = 32'd1; // always ready

    //////////////////////////////////////////////////
    // decode

    bus_word_t dac_reg;
    logic      en_mirror;

    logic      bus_rd;
    logic      bus_wr;
    logic      addr_hit;      // address is in the map
    bus_word_t rd_word;
    logic      bus_dac_upd;
    logic      gain_upd;

    assign waitrequest = set_default_on_reset;  // no back-pressure once out of reset
    assign bus_rd      = read  & ~waitrequest;
    assign bus_wr      = write & ~waitrequest;

    // bus path owns the DAC register only while en_avmm_ctrl is high
    assign bus_dac_upd = bus_wr & (address == REG_DAC) & en_avmm_ctrl;
    assign gain_upd    = dac_gain_valid & ~en_avmm_ctrl;

    always_comb begin
        addr_hit = 1'b1;
        rd_word  = '0;
        case (address)
            REG_VERSION_ID:   rd_word = VERSION_ID_WORD;
            REG_NUM_REGS:     rd_word = NUM_REGS_WORD;
            REG_DEVICE_STATE: rd_word = DEVICE_STATE_WORD;
            REG_DAC:          rd_word = dac_reg;
            REG_EN_AVMM_CTRL: rd_word = {31'd0, en_mirror};
            default:          addr_hit = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // control and register bank

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
            dac_write_stb      <= 1'b0;
            en_mirror          <= 1'b0;
            dac_reg            <= {16'd0, `DAC_DEFAULT_WORD};
        end else begin
            readdatavalid      <= bus_rd;
            writeresponsevalid <= bus_wr;
            en_mirror          <= en_avmm_ctrl;
            dac_write_stb      <= bus_dac_upd | gain_upd;

            if (bus_dac_upd) begin
                dac_reg <= writedata;          // whole word, no byte enables
            end else if (gain_upd) begin
                dac_reg[13:6] <= dac_gain;     // data field only
            end
        end
    end

    //////////////////////////////////////////////////
    // read data and response

    always_ff @(posedge clk_ifc) begin
        if (bus_rd && addr_hit) begin
            readdata <= rd_word;   // error reads keep old data
        end

        // master never issues both, write takes the response if it does
        if (bus_wr || bus_rd) begin
            response <= addr_hit ? RESP_OKAY : RESP_SLAVE_ERROR;
        end
    end

    // register already holds the new value when the strobe is seen
    assign dac_word = dac_reg[15:0];

endmodule

//--- hdl/dac_spi_shifter.sv
// 16-bit serializer driving SYNC, SCLK and DIN of the AD5601

`include "dac_cfg.svh"

module dac_spi_shifter (
    input  logic               clk_ifc,
    input  logic               set_default_on_reset,

    input  logic               shift_start,
    input  dac_pkg::dac_word_t shift_word,
    output logic               shift_busy,
    output logic               shift_done,

    output logic               sync_n,
    output logic               sclk,
    output logic               sdin
);

    import dac_pkg::*;

    localparam int HALF = `DAC_SCLK_HALF_PERIOD;
    localparam int HC_W = $clog2(HALF + 1);

    spi_state_t      state;
    logic [HC_W-1:0] half_cnt;
    logic [3:0]      bit_cnt;
    dac_word_t       shreg;
    logic            half_end;
    logic            sclk_rise;   // next edge takes sclk high

    assign half_end   = (state == SPI_SHIFT) && (half_cnt == HC_W'(HALF - 1));
    assign sclk_rise  = half_end & ~sclk;
    assign shift_busy = (state != SPI_IDLE);
    assign shift_done = (state == SPI_END);   // same cycle sync_n goes high

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            state    <= SPI_IDLE;
            sync_n   <= 1'b1;
            sclk     <= 1'b1;    // idles high
            sdin     <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (shift_start) begin
                        state    <= SPI_SHIFT;
                        sync_n   <= 1'b0;
                        sdin     <= shift_word[15];   // msb first
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end

                SPI_SHIFT: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk     <= ~sclk;
                        if (sclk_rise) begin
                            if (bit_cnt == 4'd15) begin
                                state  <= SPI_END;   // 16th period closes
                                sync_n <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 4'd1;
                                sdin    <= shreg[14];
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + HC_W'(1);
                    end
                end

                SPI_END: state <= SPI_IDLE;

                default: state <= SPI_IDLE;
            endcase
        end
    end

    // data shifts on the rising edge, DAC samples on the falling one
    always_ff @(posedge clk_ifc) begin
        if (state == SPI_IDLE && shift_start) begin
            shreg <= shift_word;
        end else if (sclk_rise) begin
            shreg <= {shreg[14:0], 1'b0};
        end
    end

endmodule

//--- hdl/dac_xfer_seq.sv
// transfer sequencer: boot word, pending write collapse,
// initdone and the per-transfer update pulse

`include "dac_cfg.svh"

module dac_xfer_seq (
    input  logic               clk_ifc,
    input  logic               set_default_on_reset,

    input  dac_pkg::dac_word_t dac_word,
    input  logic               dac_write_stb,

    output logic               shift_start,
    output dac_pkg::dac_word_t shift_word,
    input  logic               shift_busy,
    input  logic               shift_done,

    output logic               dac_reg_updated,
    output logic               initdone
);

    import dac_pkg::*;

    xfer_state_t state;
    logic        pending;     // a write arrived while shifting
    dac_word_t   pend_word;   // latest such write

    //////////////////////////////////////////////////
    // state machine

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            state           <= XFER_BOOT;
            shift_start     <= 1'b0;
            pending         <= 1'b0;
            dac_reg_updated <= 1'b0;
            initdone        <= 1'b0;
        end else begin
            shift_start     <= 1'b0;
            dac_reg_updated <= 1'b0;

            case (state)
                XFER_BOOT: begin
                    shift_start <= 1'b1;     // default word goes out first
                    state       <= XFER_BUSY;
                end

                XFER_IDLE: begin
                    if (dac_write_stb) begin
                        state       <= XFER_BUSY;
                        shift_start <= 1'b1;
                    end
                end

                XFER_BUSY: begin
                    if (shift_done) begin
                        dac_reg_updated <= 1'b1;
                        initdone        <= 1'b1;   // sticks after the boot word
                        if (pending || dac_write_stb) begin
                            shift_start <= 1'b1;   // one follow-up, latest value
                            pending     <= 1'b0;
                        end else begin
                            state <= XFER_IDLE;
                        end
                    end else if (dac_write_stb) begin
                        pending <= 1'b1;
                    end
                end

                default: state <= XFER_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // word selection

    always_ff @(posedge clk_ifc) begin
        if (dac_write_stb) begin
            pend_word <= dac_word;   // older writes are overwritten
        end

        case (state)
            XFER_BOOT: shift_word <= `DAC_DEFAULT_WORD;
            XFER_IDLE: begin
                if (dac_write_stb) begin
                    shift_word <= dac_word;
                end
            end
            XFER_BUSY: begin
                if (shift_done) begin
                    shift_word <= dac_write_stb ? dac_word : pend_word;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- include/dac_cfg.svh
// build-time constants for the AD5601 controller
// ids, default DAC word, SCLK timing and register count

`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

// module identification, read back as {version, id}
`define DAC_MODULE_ID           16'h5601
`define DAC_MODULE_VERSION      16'h0001

// word sent once after reset
// [15:14] power-down mode, [13:6] data, [5:0] don't care
`define DAC_DEFAULT_WORD        16'h4A80

// clk_ifc cycles per SCLK half period
`define DAC_SCLK_HALF_PERIOD    2

// defined word addresses start at 0
`define DAC_NUM_REGS            5

`endif

//--- run_verilator.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dac_ad5601_ctrl -f vlog.f

result=$(./obj_dir/Vtb_dac_ad5601_ctrl) || true
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -q "ALL CHECKS PASSED"

//--- tb/dac_ad5601_ctrl_properties.sv
// concurrent checks on the controller pins, bound into the top level

module dac_ad5601_ctrl_properties (
    input logic clk_ifc,
    input logic set_default_on_reset,
    input logic waitrequest,
    input logic readdatavalid,
    input logic dac_reg_updated,
    input logic sync_n,
    input logic sclk
);
    timeunit 1ns;
    timeprecision 100ps;

    // serial clock parks high between frames
    sclk_idle_high: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        sync_n |-> sclk)
        else $error("sclk low while sync_n is high");

    update_single_pulse: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        dac_reg_updated |=> !dac_reg_updated)
        else $error("dac_reg_updated high for more than one cycle");

    rdvalid_single_pulse: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        readdatavalid |=> !readdatavalid)
        else $error("readdatavalid high for more than one cycle");

    no_backpressure: assert property (@(posedge clk_ifc)
        !set_default_on_reset |-> !waitrequest)
        else $error("waitrequest high outside reset");

endmodule

bind dac_ad5601_ctrl dac_ad5601_ctrl_properties dac_ad5601_ctrl_properties_inst (
    .clk_ifc              (clk_ifc),
    .set_default_on_reset (set_default_on_reset),
    .waitrequest          (waitrequest),
    .readdatavalid        (readdatavalid),
    .dac_reg_updated      (dac_reg_updated),
    .sync_n               (sync_n),
    .sclk                 (sclk)
);

//--- tb/tb_clock_gen.sv
// testbench clock and power-on reset

module tb_clock_gen (
    output logic clk_ifc,
    output logic set_default_on_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_ifc = 1'b0;
        forever #2 clk_ifc = ~clk_ifc;   // 4 ns period
    end

    // held for 10 rising edges, released on a falling edge
    initial begin
        set_default_on_reset = 1'b1;
        repeat (10) @(posedge clk_ifc);
        @(negedge clk_ifc);
        set_default_on_reset = 1'b0;
    end

endmodule

//--- tb/tb_dac_ad5601_ctrl.sv
// testbench for the AD5601 controller
// directed tests, serial word decoder, LFSR data and result reporting

`include "dac_cfg.svh"

module tb_dac_ad5601_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    import dac_pkg::*;

    logic      clk_ifc;
    logic      set_default_on_reset;
    reg_addr_t address;
    logic      write;
    bus_word_t writedata;
    logic      read;
    logic      waitrequest;
    bus_word_t readdata;
    logic      readdatavalid;
    bus_resp_t response;
    logic      writeresponsevalid;
    logic      en_avmm_ctrl;
    dac_gain_t dac_gain;
    logic      dac_gain_valid;
    logic      dac_reg_updated;
    logic      initdone;
    logic      sync_n;
    logic      sclk;
    logic      sdin;

    dac_word_t   words[$];                   // decoded serial frames
    dac_word_t   frame_acc = '0;
    int          frame_bits = 0;
    int          upd_count = 0;
    int          tests_run = 0;
    int          checks = 0;
    int          errors = 0;
    bit          timed_out = 1'b0;
    logic [31:0] lfsr = 32'h82d2;
    bus_word_t   dac_model = {16'd0, `DAC_DEFAULT_WORD};   // expected DAC register

    tb_clock_gen clock_gen_inst (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset)
    );

    dac_ad5601_ctrl dac_ad5601_ctrl_inst (.*);

    //////////////////////////////////////////////////
    // monitors

    // DAC samples on the falling sclk edge, so does the decoder
    always @(negedge sclk) begin
        if (sync_n === 1'b0) begin
            frame_acc  = {frame_acc[14:0], sdin};
            frame_bits = frame_bits + 1;
            if (frame_bits == 16) begin
                words.push_back(frame_acc);
                frame_bits = 0;
            end
        end
    end

    always @(posedge clk_ifc) begin
        if (dac_reg_updated === 1'b1) begin
            upd_count = upd_count + 1;   // counted one cycle after the pulse
        end
    end

    //////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic void compare(input string name, input bus_word_t got,
                                    input bus_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endfunction

    function automatic void require(input bit cond, input string what);
        checks++;
        if (!cond) begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endfunction

    function automatic void report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err0);
        end
    endfunction

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // later waits return at once after this
    task automatic timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic wait_updates(input int target);
        int cycles;
        cycles = 0;
        while (!timed_out && upd_count < target && cycles < 400) begin
            @(negedge clk_ifc);
            cycles++;
        end
        if (!timed_out && upd_count < target) begin
            timeout("dac_reg_updated did not pulse");
        end
    endtask

    task automatic wait_frame_start();
        int cycles;
        cycles = 0;
        while (!timed_out && sync_n !== 1'b0 && cycles < 100) begin
            @(negedge clk_ifc);
            cycles++;
        end
        if (!timed_out && sync_n !== 1'b0) begin
            timeout("sync_n never went low");
        end
    endtask

    // one-cycle read, data and response expected on the next cycle
    task automatic bus_read(input reg_addr_t addr, output bus_word_t data,
                            output bus_resp_t resp);
        @(negedge clk_ifc);
        address = addr;
        read    = 1'b1;
        require(waitrequest === 1'b0, "waitrequest high when a read was issued");
        @(negedge clk_ifc);
        read = 1'b0;
        require(readdatavalid === 1'b1, "readdatavalid missing one cycle after read");
        data = readdata;
        resp = response;
    endtask

    task automatic read_expect(input reg_addr_t addr, input bus_word_t exp,
                               input string name);
        bus_word_t data;
        bus_resp_t resp;
        bus_read(addr, data, resp);
        compare(name, data, exp);
        compare("response", {30'd0, resp}, {30'd0, RESP_OKAY});
    endtask

    task automatic write_expect(input reg_addr_t addr, input bus_word_t data,
                                input bus_resp_t exp_resp);
        @(negedge clk_ifc);
        address   = addr;
        writedata = data;
        write     = 1'b1;
        require(waitrequest === 1'b0, "waitrequest high when a write was issued");
        @(negedge clk_ifc);
        write = 1'b0;
        require(writeresponsevalid === 1'b1, "writeresponsevalid missing after write");
        compare("response", {30'd0, response}, {30'd0, exp_resp});
    endtask

    function automatic void check_last_word(input int nw, input dac_word_t exp);
        require(words.size() == nw + 1, "expected exactly one new serial word");
        if (words.size() > nw) begin
            compare("sdin word", {16'd0, words[nw]}, {16'd0, exp});
        end
    endfunction

    //////////////////////////////////////////////////
    // tests

    task automatic test_boot();
        int err0;
        err0 = errors;
        require(sync_n === 1'b1 && initdone === 1'b0, "link or initdone active after reset");
        wait_updates(1);
        compare("initdone", {31'd0, initdone}, 32'd1);
        repeat (100) @(negedge clk_ifc);   // quiet window longer than one frame
        check_last_word(0, `DAC_DEFAULT_WORD);
        require(upd_count == 1 && sync_n === 1'b1, "boot gave more than one transfer");
        compare("initdone", {31'd0, initdone}, 32'd1);
        report_test("boot", err0);
    endtask

    task automatic test_reads();
        int        err0;
        bus_word_t data;
        bus_resp_t resp;
        err0 = errors;
        read_expect(REG_VERSION_ID, {`DAC_MODULE_VERSION, `DAC_MODULE_ID}, "readdata");
        read_expect(REG_NUM_REGS, 32'd5, "readdata");
        read_expect(REG_DEVICE_STATE, 32'd1, "readdata");
        read_expect(REG_EN_AVMM_CTRL, 32'd1, "readdata");
        en_avmm_ctrl = 1'b0;
        read_expect(REG_EN_AVMM_CTRL, 32'd0, "readdata");
        en_avmm_ctrl = 1'b1;
        read_expect(REG_EN_AVMM_CTRL, 32'd1, "readdata");
        bus_read(4'd5, data, resp);
        compare("response", {30'd0, resp}, {30'd0, RESP_SLAVE_ERROR});
        compare("readdata", data, 32'd1);   // held from the last good read
        report_test("register reads", err0);
    endtask

    task automatic test_bus_path();
        int        err0;
        int        nw;
        bus_word_t word;
        err0 = errors;
        word = rand_bits(32);
        nw   = words.size();
        write_expect(REG_DAC, word, RESP_OKAY);
        wait_updates(2);
        check_last_word(nw, word[15:0]);
        dac_model = word;
        read_expect(REG_DAC, dac_model, "readdata");
        write_expect(REG_VERSION_ID, rand_bits(32), RESP_OKAY);
        read_expect(REG_VERSION_ID, {`DAC_MODULE_VERSION, `DAC_MODULE_ID}, "readdata");
        write_expect(4'd9, rand_bits(32), RESP_SLAVE_ERROR);
        report_test("bus path", err0);
    endtask

    task automatic test_gain_path();
        int          err0;
        int          nw;
        logic [31:0] gain;
        err0 = errors;
        en_avmm_ctrl = 1'b0;
        write_expect(REG_DAC, rand_bits(32), RESP_OKAY);
        read_expect(REG_DAC, dac_model, "readdata");
        require(sync_n === 1'b1 && upd_count == 2, "REG_DAC write with en_avmm_ctrl low");
        gain = rand_bits(8);
        nw   = words.size();
        @(negedge clk_ifc);
        dac_gain       = gain[7:0];
        dac_gain_valid = 1'b1;
        @(negedge clk_ifc);
        dac_gain_valid = 1'b0;
        dac_model[13:6] = gain[7:0];
        wait_updates(3);
        check_last_word(nw, dac_model[15:0]);
        read_expect(REG_DAC, dac_model, "readdata");
        en_avmm_ctrl = 1'b1;
        report_test("gain path", err0);
    endtask

    // B and C land during A, only C follows
    task automatic test_collapse();
        int        err0;
        int        nw;
        bus_word_t a;
        bus_word_t b;
        bus_word_t c;
        err0 = errors;
        a  = rand_bits(32);
        b  = rand_bits(32);
        c  = rand_bits(32);
        nw = words.size();
        write_expect(REG_DAC, a, RESP_OKAY);
        wait_frame_start();
        write_expect(REG_DAC, b, RESP_OKAY);
        write_expect(REG_DAC, c, RESP_OKAY);
        wait_updates(5);
        require(words.size() == nw + 2, "expected exactly two serial words");
        if (words.size() >= nw + 2) begin
            compare("first sdin word", {16'd0, words[nw]}, {16'd0, a[15:0]});
            compare("second sdin word", {16'd0, words[nw + 1]}, {16'd0, c[15:0]});
        end
        require(sync_n === 1'b1 && upd_count == 5, "a third transfer followed");
        compare("initdone", {31'd0, initdone}, 32'd1);
        read_expect(REG_DAC, c, "readdata");
        report_test("collapsed writes", err0);
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int cycles;
        address        = '0;
        write          = 1'b0;
        writedata      = '0;
        read           = 1'b0;
        en_avmm_ctrl   = 1'b1;
        dac_gain       = '0;
        dac_gain_valid = 1'b0;
        cycles         = 0;
        @(negedge clk_ifc);
        require(waitrequest === 1'b1, "waitrequest low during reset");
        while (set_default_on_reset !== 1'b0 && cycles < 50) begin
            @(negedge clk_ifc);
            cycles++;
        end
        if (set_default_on_reset !== 1'b0) begin
            timeout("reset was never released");
        end
        if (!timed_out) begin
            test_boot();
            test_reads();
            test_bus_path();
            test_gain_path();
            test_collapse();
        end
        finish_run();
    end

endmodule

//--- vlog.f
+incdir+include
hdl/dac_pkg.sv
hdl/dac_reg_map.sv
hdl/dac_xfer_seq.sv
hdl/dac_spi_shifter.sv
hdl/dac_ad5601_ctrl.sv
tb/tb_clock_gen.sv
tb/dac_ad5601_ctrl_properties.sv
tb/tb_dac_ad5601_ctrl.sv
